// File: common/rx_tx_pkg.sv
package rx_tx_pkg;

    // gmii framing bytes
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int         PREAMBLE_LEN  = 7;  // preamble bytes ahead of the sfd

    // dst + src + ethertype, only the 12 address bytes are decoded
    localparam int HDR_LEN = 14;

    // crc register value after the fcs has gone through, in msb-first bit order
    localparam logic [31:0] CRC32_RESIDUE = 32'hC704DD7B;

    // one byte of the reflected crc-32, lsb of the byte first
    // start from all ones; the fcs on the wire is the inverted register, low byte first
    function automatic logic [31:0] crc32_next(input logic [7:0] data, input logic [31:0] crc);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ 32'hEDB88320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // one word of the cdc fifo
    typedef struct packed {
        logic [7:0] data;
        logic       er;    // rx_er seen so far in this frame
        logic       last;  // final byte of the frame
    } gmii_word_t;

    // one beat of the frame stream
    typedef struct packed {
        logic [7:0] data;
        logic       sof;
        logic       eof;
        logic       error;  // only valid together with eof
    } frame_beat_t;

    // first byte on the wire sits in the top byte
    typedef struct packed {
        logic [5:0][7:0] dst;
        logic [5:0][7:0] src;
    } mac_hdr_t;

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        PAYLOAD
    } rx_state_e;

endpackage

// File: async_fifo/fifo_ptr_sync.sv
module fifo_ptr_sync #(
    parameter int WIDTH = 5
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic [WIDTH-1:0] gray_i,
    output logic [WIDTH-1:0] gray_o
);

    logic [WIDTH-1:0] meta_q;  // first stage, may go metastable

    // gray code changes one bit per step, so the pair of flops is safe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q <= '0;
            gray_o <= '0;
        end else begin
            meta_q <= gray_i;
            gray_o <= meta_q;
        end
    end

endmodule

// File: async_fifo/async_fifo.sv
module async_fifo #(
    parameter int FIFO_ADDR_W = 4
) (
    input  logic                  wr_clk_i,
    input  logic                  wr_rst_n_i,
    input  logic                  wr_en_i,
    input  rx_tx_pkg::gmii_word_t wr_word_i,
    output logic                  wr_full_o,
    input  logic                  rd_clk_i,
    input  logic                  rd_rst_n_i,
    input  logic                  rd_en_i,
    output rx_tx_pkg::gmii_word_t rd_word_o,
    output logic                  rd_empty_o
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;
    // full when the top two gray bits differ and the rest match
    localparam logic [FIFO_ADDR_W:0] FULL_MASK = (FIFO_ADDR_W + 1)'(3) << (FIFO_ADDR_W - 1);

    rx_tx_pkg::gmii_word_t mem [DEPTH];

    logic [FIFO_ADDR_W:0] wr_bin_q;
    logic [FIFO_ADDR_W:0] wr_gray_q;
    logic [FIFO_ADDR_W:0] wr_bin_d;
    logic [FIFO_ADDR_W:0] wr_gray_d;
    logic [FIFO_ADDR_W:0] rd_bin_q;
    logic [FIFO_ADDR_W:0] rd_gray_q;
    logic [FIFO_ADDR_W:0] rd_bin_d;
    logic [FIFO_ADDR_W:0] rd_gray_d;
    logic [FIFO_ADDR_W:0] rd_gray_wclk;  // read pointer seen by the writer
    logic [FIFO_ADDR_W:0] wr_gray_rclk;  // write pointer seen by the reader
    logic                 wr_push;
    logic                 rd_pop;

    // write side
    assign wr_push   = wr_en_i && !wr_full_o;
    assign wr_bin_d  = wr_bin_q + (FIFO_ADDR_W + 1)'(wr_push);
    assign wr_gray_d = (wr_bin_d >> 1) ^ wr_bin_d;

    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
            wr_full_o <= 1'b0;
        end else begin
            wr_bin_q  <= wr_bin_d;
            wr_gray_q <= wr_gray_d;
            wr_full_o <= (wr_gray_d == (rd_gray_wclk ^ FULL_MASK));
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_push) begin
            mem[wr_bin_q[FIFO_ADDR_W-1:0]] <= wr_word_i;
        end
    end

    // read side, head word shows ahead of the pop
    assign rd_pop    = rd_en_i && !rd_empty_o;
    assign rd_bin_d  = rd_bin_q + (FIFO_ADDR_W + 1)'(rd_pop);
    assign rd_gray_d = (rd_bin_d >> 1) ^ rd_bin_d;
    assign rd_word_o = mem[rd_bin_q[FIFO_ADDR_W-1:0]];

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_bin_q   <= '0;
            rd_gray_q  <= '0;
            rd_empty_o <= 1'b1;
        end else begin
            rd_bin_q   <= rd_bin_d;
            rd_gray_q  <= rd_gray_d;
            rd_empty_o <= (rd_gray_d == wr_gray_rclk);
        end
    end

    fifo_ptr_sync #(
        .WIDTH (FIFO_ADDR_W + 1)
    ) u_rd2wr_sync (
        .clk_i   (wr_clk_i),
        .rst_n_i (wr_rst_n_i),
        .gray_i  (rd_gray_q),
        .gray_o  (rd_gray_wclk)
    );

    fifo_ptr_sync #(
        .WIDTH (FIFO_ADDR_W + 1)
    ) u_wr2rd_sync (
        .clk_i   (rd_clk_i),
        .rst_n_i (rd_rst_n_i),
        .gray_i  (wr_gray_q),
        .gray_o  (wr_gray_rclk)
    );

endmodule

// File: source/gmii_rx_capture.sv
module gmii_rx_capture (
    input  logic                  gmii_rx_clk_i,
    input  logic                  switch_rst_n_i,
    input  logic [7:0]            gmii_rx_data_i,
    input  logic                  gmii_rx_dv_i,
    input  logic                  gmii_rx_er_i,
    input  logic                  wr_full_i,
    output logic                  wr_rst_n_o,
    output logic                  wr_en_o,
    output rx_tx_pkg::gmii_word_t wr_word_o
);

    logic [1:0] rst_sync_q;
    logic [7:0] hold_data_q;   // byte waiting for the next dv sample
    logic       hold_valid_q;  // also rx_dv of the previous cycle
    logic       er_q;

    // reset asserts at once, releases on the gmii clock
    always_ff @(posedge gmii_rx_clk_i or negedge switch_rst_n_i) begin
        if (!switch_rst_n_i) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign wr_rst_n_o = rst_sync_q[1];

    always_ff @(posedge gmii_rx_clk_i or negedge wr_rst_n_o) begin
        if (!wr_rst_n_o) begin
            hold_valid_q <= 1'b0;
            er_q         <= 1'b0;
        end else begin
            hold_valid_q <= gmii_rx_dv_i;
            if (gmii_rx_dv_i) begin
                er_q <= (hold_valid_q & er_q) | gmii_rx_er_i;  // restart on a new frame
            end
        end
    end

    always_ff @(posedge gmii_rx_clk_i) begin
        if (gmii_rx_dv_i) begin
            hold_data_q <= gmii_rx_data_i;
        end
    end

    // dv already low means the held byte closes the frame
    assign wr_word_o.data = hold_data_q;
    assign wr_word_o.er   = er_q;
    assign wr_word_o.last = !gmii_rx_dv_i;
    assign wr_en_o        = hold_valid_q && !wr_full_i;  // dropped when full

endmodule

// File: rx_mac/rx_mac_control.sv
module rx_mac_control (
    input  logic                   switch_clk,
    input  logic                   switch_rst_n,
    input  rx_tx_pkg::gmii_word_t  rd_word_i,
    input  logic                   rd_empty_i,
    input  logic                   frame_ready_i,
    output logic                   rd_en_o,
    output rx_tx_pkg::frame_beat_t frame_o,
    output logic                   frame_valid_o,
    output rx_tx_pkg::mac_hdr_t    hdr_o,
    output logic                   hdr_valid_o
);

    localparam int ADDR_LEN = rx_tx_pkg::HDR_LEN - 2;  // ethertype is not decoded
    localparam int HDR_W    = $bits(rx_tx_pkg::mac_hdr_t);

    rx_tx_pkg::rx_state_e   state_q;
    rx_tx_pkg::rx_state_e   state_d;
    rx_tx_pkg::frame_beat_t beat_d;
    rx_tx_pkg::mac_hdr_t    hdr_d;

    logic [3:0]  cnt_q;    // preamble bytes, then header bytes
    logic [3:0]  cnt_d;
    logic        drain_q;  // discarding the rest of a rejected frame
    logic        drain_d;
    logic [31:0] crc_q;
    logic [31:0] crc_d;
    logic [31:0] crc_upd;
    logic [31:0] crc_msb;
    logic        byte_ok;
    logic        out_free;
    logic        beat_load;
    logic        hdr_pulse;

    assign out_free = !frame_valid_o || frame_ready_i;  // output register empty or leaving

    // crc including the word at the fifo head
    assign crc_upd = rx_tx_pkg::crc32_next(rd_word_i.data, crc_q);

    always_comb begin
        crc_msb = {<<{crc_upd}};  // residue is kept msb first
    end

    // candidate beat from the head word, loaded only on a pop in header/payload
    always_comb begin
        beat_d.data  = rd_word_i.data;
        beat_d.sof   = (state_q == rx_tx_pkg::HEADER) && (cnt_q == 4'd0);
        beat_d.eof   = rd_word_i.last;
        beat_d.error = rd_word_i.last && ((state_q == rx_tx_pkg::HEADER) || rd_word_i.er ||
                                          (crc_msb != rx_tx_pkg::CRC32_RESIDUE));
    end

    always_comb begin
        state_d   = state_q;
        cnt_d     = cnt_q;
        drain_d   = drain_q;
        crc_d     = crc_q;
        hdr_d     = hdr_o;
        rd_en_o   = 1'b0;
        beat_load = 1'b0;
        hdr_pulse = 1'b0;
        byte_ok   = 1'b0;

        case (state_q)
            rx_tx_pkg::IDLE: begin
                if (!rd_empty_i) begin
                    rd_en_o = 1'b1;  // never waits on ready
                    if (!drain_q && !rd_word_i.last &&
                        rd_word_i.data == rx_tx_pkg::PREAMBLE_BYTE) begin
                        state_d = rx_tx_pkg::PREAMBLE;
                        cnt_d   = 4'd1;
                    end else begin
                        drain_d = !rd_word_i.last;  // stray bytes, skip to frame end
                    end
                end
            end

            rx_tx_pkg::PREAMBLE: begin
                if (!rd_empty_i) begin
                    rd_en_o = 1'b1;
                    if (cnt_q < rx_tx_pkg::PREAMBLE_LEN) begin
                        byte_ok = (rd_word_i.data == rx_tx_pkg::PREAMBLE_BYTE);
                    end else begin
                        byte_ok = (rd_word_i.data == rx_tx_pkg::SFD_BYTE);
                    end

                    if (!byte_ok || rd_word_i.last) begin
                        state_d = rx_tx_pkg::IDLE;
                        drain_d = !rd_word_i.last;
                    end else if (cnt_q == 4'(rx_tx_pkg::PREAMBLE_LEN)) begin
                        state_d = rx_tx_pkg::HEADER;
                        cnt_d   = 4'd0;
                        crc_d   = '1;  // crc preset
                    end else begin
                        cnt_d = cnt_q + 4'd1;
                    end
                end
            end

            rx_tx_pkg::HEADER, rx_tx_pkg::PAYLOAD: begin
                if (!rd_empty_i && out_free) begin
                    rd_en_o   = 1'b1;
                    beat_load = 1'b1;
                    crc_d     = crc_upd;
                    if (state_q == rx_tx_pkg::HEADER) begin
                        cnt_d = cnt_q + 4'd1;
                        if (cnt_q < ADDR_LEN) begin
                            hdr_d = {hdr_o[HDR_W-9:0], rd_word_i.data};
                        end
                        hdr_pulse = (cnt_q == 4'(ADDR_LEN - 1));  // last src byte
                        if (cnt_q == 4'(rx_tx_pkg::HDR_LEN - 1)) begin
                            state_d = rx_tx_pkg::PAYLOAD;
                        end
                    end
                    if (rd_word_i.last) begin
                        state_d = rx_tx_pkg::IDLE;
                    end
                end
            end

            default: begin
                state_d = rx_tx_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state_q       <= rx_tx_pkg::IDLE;
            cnt_q         <= 4'd0;
            drain_q       <= 1'b0;
            frame_valid_o <= 1'b0;
            hdr_valid_o   <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            drain_q     <= drain_d;
            hdr_valid_o <= hdr_pulse;
            if (beat_load) begin
                frame_valid_o <= 1'b1;
            end else if (frame_ready_i) begin
                frame_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge switch_clk) begin
        crc_q <= crc_d;
        hdr_o <= hdr_d;
        if (beat_load) begin
            frame_o <= beat_d;  // held until the handshake
        end
    end

endmodule

// File: source/rx_port_top.sv
module rx_port_top #(
    parameter int FIFO_ADDR_W = 4
) (
    input  logic                   switch_clk,
    input  logic                   switch_rst_n,
    input  logic                   gmii_rx_clk_i,
    input  logic [7:0]             gmii_rx_data_i,
    input  logic                   gmii_rx_dv_i,
    input  logic                   gmii_rx_er_i,
    input  logic                   frame_ready_i,
    output rx_tx_pkg::frame_beat_t frame_o,
    output logic                   frame_valid_o,
    output rx_tx_pkg::mac_hdr_t    hdr_o,
    output logic                   hdr_valid_o
);

    logic                  wr_rst_n;  // reset in the gmii domain
    logic                  wr_en;
    logic                  wr_full;
    rx_tx_pkg::gmii_word_t wr_word;
    logic                  rd_en;
    logic                  rd_empty;
    rx_tx_pkg::gmii_word_t rd_word;

    gmii_rx_capture u_capture (
        .gmii_rx_clk_i  (gmii_rx_clk_i),
        .switch_rst_n_i (switch_rst_n),
        .gmii_rx_data_i (gmii_rx_data_i),
        .gmii_rx_dv_i   (gmii_rx_dv_i),
        .gmii_rx_er_i   (gmii_rx_er_i),
        .wr_full_i      (wr_full),
        .wr_rst_n_o     (wr_rst_n),
        .wr_en_o        (wr_en),
        .wr_word_o      (wr_word)
    );

    async_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_cdc_fifo (
        .wr_clk_i   (gmii_rx_clk_i),
        .wr_rst_n_i (wr_rst_n),
        .wr_en_i    (wr_en),
        .wr_word_i  (wr_word),
        .wr_full_o  (wr_full),
        .rd_clk_i   (switch_clk),
        .rd_rst_n_i (switch_rst_n),
        .rd_en_i    (rd_en),
        .rd_word_o  (rd_word),
        .rd_empty_o (rd_empty)
    );

    rx_mac_control u_mac_ctrl (
        .switch_clk    (switch_clk),
        .switch_rst_n  (switch_rst_n),
        .rd_word_i     (rd_word),
        .rd_empty_i    (rd_empty),
        .frame_ready_i (frame_ready_i),
        .rd_en_o       (rd_en),
        .frame_o       (frame_o),
        .frame_valid_o (frame_valid_o),
        .hdr_o         (hdr_o),
        .hdr_valid_o   (hdr_valid_o)
    );

endmodule

// File: tb/rx_port_sva.sv
module rx_port_sva (
    input logic                   switch_clk,
    input logic                   switch_rst_n,
    input rx_tx_pkg::frame_beat_t frame_i,
    input logic                   frame_valid_i,
    input logic                   frame_ready_i,
    input logic                   rd_en_i,
    input logic                   rd_empty_i,
    input logic                   hdr_valid_i,
    input rx_tx_pkg::rx_state_e   state_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // polled by the testbench

    // stalled beat must stay put until it transfers
    a_beat_hold: assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        frame_valid_i && !frame_ready_i |=> frame_valid_i && $stable(frame_i))
    else begin
        $error("pending frame beat changed or dropped while ready was low");
        fail_count++;
    end

    a_no_pop_empty: assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        rd_en_i |-> !rd_empty_i)
    else begin
        $error("fifo popped while empty");
        fail_count++;
    end

    // first cycle out of reset
    a_reset_state: assert property (@(posedge switch_clk)
        $rose(switch_rst_n) |-> !frame_valid_i && !hdr_valid_i && state_i == rx_tx_pkg::IDLE)
    else begin
        $error("outputs or state not cleared by reset");
        fail_count++;
    end

endmodule

bind rx_mac_control rx_port_sva u_sva (
    .switch_clk    (switch_clk),
    .switch_rst_n  (switch_rst_n),
    .frame_i       (frame_o),
    .frame_valid_i (frame_valid_o),
    .frame_ready_i (frame_ready_i),
    .rd_en_i       (rd_en_o),
    .rd_empty_i    (rd_empty_i),
    .hdr_valid_i   (hdr_valid_o),
    .state_i       (state_q)
);

// File: tb/rx_port_tb.sv
module rx_port_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] RAND_SEED  = 32'h8f3181a8;
    localparam int          MAX_CASES  = 64;
    localparam int          IFG_CYCLES = 12;  // idle gmii cycles between frames

    logic                   switch_clk;
    logic                   switch_rst_n;
    logic                   gmii_rx_clk_i;
    logic [7:0]             gmii_rx_data_i;
    logic                   gmii_rx_dv_i;
    logic                   gmii_rx_er_i;
    logic                   frame_ready_i;
    rx_tx_pkg::frame_beat_t frame_o;
    logic                   frame_valid_o;
    rx_tx_pkg::mac_hdr_t    hdr_o;
    logic                   hdr_valid_o;

    rx_tx_pkg::frame_beat_t exp_beat_q[$];
    rx_tx_pkg::mac_hdr_t    exp_hdr_q[$];
    logic [71:0]            case_mem [MAX_CASES];  // mode, length, seed, fcs flag, er index
    int                     num_cases      = 0;
    int                     beats_seen     = 0;
    int                     hdrs_seen      = 0;
    logic [31:0]            ready_rand     = RAND_SEED;

    rx_port_top #(
        .FIFO_ADDR_W (4)
    ) i_dut (
        .switch_clk     (switch_clk),
        .switch_rst_n   (switch_rst_n),
        .gmii_rx_clk_i  (gmii_rx_clk_i),
        .gmii_rx_data_i (gmii_rx_data_i),
        .gmii_rx_dv_i   (gmii_rx_dv_i),
        .gmii_rx_er_i   (gmii_rx_er_i),
        .frame_ready_i  (frame_ready_i),
        .frame_o        (frame_o),
        .frame_valid_o  (frame_valid_o),
        .hdr_o          (hdr_o),
        .hdr_valid_o    (hdr_valid_o)
    );

    initial begin
        switch_clk = 1'b0;
        forever #5 switch_clk = ~switch_clk;
    end

    initial begin
        gmii_rx_clk_i = 1'b0;
        forever #8 gmii_rx_clk_i = ~gmii_rx_clk_i;  // slower than the switch side
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_beat(input rx_tx_pkg::frame_beat_t exp,
                              input rx_tx_pkg::frame_beat_t act);
        if (act !== exp) begin
            $display("MISMATCH frame_o beat %0d expected %h actual %h", beats_seen, exp, act);
            abort_run();
        end
    endtask

    task automatic check_hdr(input rx_tx_pkg::mac_hdr_t exp, input rx_tx_pkg::mac_hdr_t act);
        if (act !== exp) begin
            $display("MISMATCH hdr_o header %0d expected %h actual %h", hdrs_seen, exp, act);
            abort_run();
        end
    endtask

    task automatic drive_gmii_byte(input logic [7:0] data, input logic er);
        @(posedge gmii_rx_clk_i);
        #1;
        gmii_rx_dv_i   = 1'b1;
        gmii_rx_data_i = data;
        gmii_rx_er_i   = er;
    endtask

    task automatic idle_gmii(input int cycles);
        repeat (cycles) begin
            @(posedge gmii_rx_clk_i);
            #1;
            gmii_rx_dv_i   = 1'b0;
            gmii_rx_data_i = 8'h00;
            gmii_rx_er_i   = 1'b0;
        end
    endtask

    // builds one frame, queues what the port should deliver, then puts it on the wire
    task automatic send_case(input logic [71:0] entry);
        logic [3:0]             mode;
        int                     len;
        logic [31:0]            state;
        logic                   corrupt;
        int                     er_idx;
        logic [7:0]             body[$];
        logic [31:0]            crc;
        logic [31:0]            fcs;
        logic [7:0]             pre_byte;
        rx_tx_pkg::mac_hdr_t    hdr;
        rx_tx_pkg::frame_beat_t beat;

        mode    = entry[71:68];
        len     = int'(entry[67:52]);
        state   = RAND_SEED ^ entry[51:20];
        corrupt = entry[16];
        er_idx  = (entry[15:0] == 16'hFFFF) ? -1 : int'(entry[15:0]);

        for (int i = 0; i < rx_tx_pkg::HDR_LEN + len; i++) begin
            state = next_rand(state);
            body.push_back(state[15:8]);
        end
        crc = '1;
        foreach (body[i]) begin
            crc = rx_tx_pkg::crc32_next(body[i], crc);
        end
        fcs = ~crc;
        if (corrupt) begin
            fcs[5] = ~fcs[5];
        end
        for (int i = 0; i < 4; i++) begin
            body.push_back(fcs[8*i +: 8]);  // low byte goes out first
        end

        if (mode == 4'd0) begin
            for (int i = 0; i < 6; i++) begin
                hdr.dst[5-i] = body[i];
                hdr.src[5-i] = body[6+i];
            end
            exp_hdr_q.push_back(hdr);
            foreach (body[i]) begin
                beat.data  = body[i];
                beat.sof   = (i == 0);
                beat.eof   = (i == body.size() - 1);
                beat.error = beat.eof && (corrupt || er_idx >= 0);
                exp_beat_q.push_back(beat);
            end
        end

        for (int k = 0; k < rx_tx_pkg::PREAMBLE_LEN; k++) begin
            pre_byte = (mode == 4'd1 && k == 3) ? 8'h5A : rx_tx_pkg::PREAMBLE_BYTE;
            drive_gmii_byte(pre_byte, 1'b0);
        end
        drive_gmii_byte((mode == 4'd2) ? 8'hD4 : rx_tx_pkg::SFD_BYTE, 1'b0);
        foreach (body[i]) begin
            drive_gmii_byte(body[i], i == er_idx);
        end
        idle_gmii(IFG_CYCLES);
    endtask

    // ready low in about a quarter of the cycles
    always @(posedge switch_clk) begin
        #1;
        ready_rand    = next_rand(ready_rand);
        frame_ready_i = (ready_rand[1:0] != 2'b00);
    end

    always @(posedge switch_clk) begin
        if (switch_rst_n && frame_valid_o && frame_ready_i) begin
            if (exp_beat_q.size() == 0) begin
                $display("frame beat %h arrived when no beat was expected", frame_o);
                abort_run();
            end else begin
                check_beat(exp_beat_q.pop_front(), frame_o);
                beats_seen++;
            end
        end
    end

    always @(posedge switch_clk) begin
        if (switch_rst_n && hdr_valid_o) begin
            if (exp_hdr_q.size() == 0) begin
                $display("header pulse %h arrived when no header was expected", hdr_o);
                abort_run();
            end else begin
                check_hdr(exp_hdr_q.pop_front(), hdr_o);
                hdrs_seen++;
            end
        end
    end

    always @(posedge switch_clk) begin
        if (i_dut.u_mac_ctrl.u_sva.fail_count != 0) begin
            $display("an assertion in rx_mac_control failed, see the error above");
            abort_run();
        end
    end

    initial begin : watchdog
        wait (num_cases != 0);
        #(40_000 + 2_000 * num_cases);
        $display("run timed out with %0d beats and %0d headers still outstanding",
                 exp_beat_q.size(), exp_hdr_q.size());
        abort_run();
    end

    initial begin : main
        int count;
        switch_rst_n   = 1'b0;
        gmii_rx_data_i = 8'h00;
        gmii_rx_dv_i   = 1'b0;
        gmii_rx_er_i   = 1'b0;
        frame_ready_i  = 1'b0;
        for (int i = 0; i < MAX_CASES; i++) begin
            case_mem[i] = '1;  // mode f marks the end of the list
        end
        $readmemh("tb/rx_port_cases.txt", case_mem);
        count = 0;
        while (count < MAX_CASES && case_mem[count][71:68] != 4'hF) begin
            count++;
        end

        if (count == 0) begin
            $display("no frames found in tb/rx_port_cases.txt");
            abort_run();
        end else begin
            num_cases = count;
            repeat (2) @(posedge switch_clk);
            #1 switch_rst_n = 1'b1;
            repeat (4) @(posedge gmii_rx_clk_i);  // gmii side reset release
            for (int i = 0; i < num_cases; i++) begin
                send_case(case_mem[i]);
            end
            wait (exp_beat_q.size() == 0 && exp_hdr_q.size() == 0);
            repeat (100) @(posedge switch_clk);  // room for stray beats to show up
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: all.f
common/rx_tx_pkg.sv
async_fifo/fifo_ptr_sync.sv
async_fifo/async_fifo.sv
source/gmii_rx_capture.sv
rx_mac/rx_mac_control.sv
source/rx_port_top.sv
tb/rx_port_sva.sv
tb/rx_port_tb.sv

// File: Bender.yml
package:
  name: rx_port

dependencies: {}

sources:
  - common/rx_tx_pkg.sv
  - async_fifo/fifo_ptr_sync.sv
  - async_fifo/async_fifo.sv
  - source/gmii_rx_capture.sv
  - rx_mac/rx_mac_control.sv
  - source/rx_port_top.sv

  - target: test
    files:
      - tb/rx_port_sva.sv
      - tb/rx_port_tb.sv

// File: tb/rx_port_cases.txt
// mode_paylen_seed_fcsbad_eridx, hex, one frame per line
// mode 0 good, 1 bad preamble byte, 2 bad sfd; eridx counts from the first dst byte, ffff = none
0_002e_00000001_0_ffff
0_0040_00000002_0_ffff
0_002e_00000003_1_ffff
0_0064_00000004_0_0014
1_003c_00000005_0_ffff
0_002e_00000006_0_ffff
2_0050_00000007_0_ffff
0_012c_00000008_0_ffff
0_002f_00000009_0_ffff
0_00c8_0000000a_1_ffff
0_002e_0000000b_0_0000
0_0080_0000000c_0_ffff
1_002e_0000000d_0_ffff
2_0030_0000000e_0_ffff
0_00fa_0000000f_0_ffff
0_003c_00000010_0_004d
0_012c_00000011_1_ffff
0_0033_00000012_0_ffff
